// ==== source/bus_pkg.sv ====
package bus_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int ID_WIDTH   = 4;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [ID_WIDTH-1:0]   id_t;

    // Requester IDs carried with every transaction
    localparam id_t ID_FETCH = 4'd0;
    localparam id_t ID_DATA  = 4'd1;

    // Timer window in the address map
    localparam addr_t CLINT_BASE      = 32'h0200_0000;
    localparam addr_t CLINT_SIZE      = 32'h0001_0000;
    localparam addr_t MTIMECMP_OFFSET = 32'h0000_4000;
    localparam addr_t MTIME_OFFSET    = 32'h0000_BFF8;

    // Single-beat request
    typedef struct packed {
        id_t   id;
        addr_t addr;
        logic  write;
        data_t data;
        strb_t strb;
    } bus_req_t;

    // Response carrying read data or zero for a write
    typedef struct packed {
        id_t   id;
        data_t data;
    } bus_rsp_t;

endpackage

// ==== source/request_arbiter.sv ====
`timescale 1ns/1ps

module request_arbiter (
    input  logic              clock,
    input  logic              reset,
    input  logic              fetch_req_valid,
    input  bus_pkg::addr_t    fetch_addr,
    output logic              fetch_req_ready,
    input  logic              data_req_valid,
    input  bus_pkg::bus_req_t data_req,
    output logic              data_req_ready,
    input  logic              rsp_done,
    output logic              clint_req_valid,
    output bus_pkg::bus_req_t clint_req,
    input  logic              clint_req_ready,
    output logic              ext_req_valid,
    output bus_pkg::bus_req_t ext_req,
    input  logic              ext_req_ready
);
    import bus_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT_RSP
    } state_t;

    state_t   state;
    bus_req_t grant_req;
    bus_req_t req_q;
    logic     grant_clint;
    logic     clint_q;
    logic     accept;
    logic     sent;

    // Data port wins when both ask in the same cycle
    assign data_req_ready  = (state == IDLE) && data_req_valid;
    assign fetch_req_ready = (state == IDLE) && fetch_req_valid && !data_req_valid;
    assign accept          = data_req_ready || fetch_req_ready;

    always_comb begin
        if (data_req_valid) begin
            grant_req    = data_req;
            grant_req.id = ID_DATA;
        end else begin
            grant_req       = '0;
            grant_req.id    = ID_FETCH;
            grant_req.addr  = fetch_addr;
            grant_req.write = 1'b0;
        end
    end

    // Timer window decode
    assign grant_clint = (grant_req.addr >= CLINT_BASE) &&
                         (grant_req.addr < CLINT_BASE + CLINT_SIZE);

    always_ff @(posedge clock) begin
        if (accept) begin
            req_q   <= grant_req;
            clint_q <= grant_clint;
        end
    end

    assign clint_req_valid = (state == SEND) && clint_q;
    assign ext_req_valid   = (state == SEND) && !clint_q;
    assign clint_req       = req_q;
    assign ext_req         = req_q;

    assign sent = (clint_req_valid && clint_req_ready) || (ext_req_valid && ext_req_ready);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= SEND;
                    end
                end
                SEND: begin
                    // A zero-latency target may answer in the same cycle
                    if (sent) begin
                        state <= rsp_done ? IDLE : WAIT_RSP;
                    end
                end
                WAIT_RSP: begin
                    if (rsp_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== source/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer (
    input  logic              clock,
    input  logic              reset,
    input  logic              req_valid,
    input  bus_pkg::bus_req_t req,
    output logic              req_ready,
    output logic              rsp_valid,
    output bus_pkg::bus_rsp_t rsp,
    input  logic              rsp_ready,
    output logic              timer_irq
);
    import bus_pkg::*;

    data_t mtime;
    data_t mtimecmp;
    data_t rd_data;
    addr_t offset;
    logic  accept;
    logic  wr_mtime;
    logic  wr_mtimecmp;

    function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t strb);
        data_t result;
        result = old_val;
        for (int i = 0; i < STRB_WIDTH; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return result;
    endfunction

    // One request at a time, blocked while a response waits
    assign req_ready = req_valid && !rsp_valid;
    assign accept    = req_valid && req_ready;

    assign offset      = req.addr - CLINT_BASE;
    assign wr_mtime    = accept && req.write && (offset == MTIME_OFFSET);
    assign wr_mtimecmp = accept && req.write && (offset == MTIMECMP_OFFSET);

    always_comb begin
        case (offset)
            MTIMECMP_OFFSET: rd_data = mtimecmp;
            MTIME_OFFSET:    rd_data = mtime;
            default:         rd_data = '0;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mtime    <= '0;
            mtimecmp <= '1;
        end else begin
            if (wr_mtime) begin
                mtime <= merge_bytes(mtime, req.data, req.strb);
            end else begin
                mtime <= mtime + data_t'(1);
            end
            if (wr_mtimecmp) begin
                mtimecmp <= merge_bytes(mtimecmp, req.data, req.strb);
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (rsp_valid && rsp_ready) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            rsp.id   <= req.id;
            rsp.data <= req.write ? '0 : rd_data;
        end
    end

    assign timer_irq = (mtime >= mtimecmp);

endmodule

// ==== source/response_merge.sv ====
`timescale 1ns/1ps

module response_merge (
    input  logic              clint_rsp_valid,
    input  bus_pkg::bus_rsp_t clint_rsp,
    output logic              clint_rsp_ready,
    input  logic              ext_rsp_valid,
    input  bus_pkg::bus_rsp_t ext_rsp,
    output logic              ext_rsp_ready,
    output logic              fetch_rsp_valid,
    output bus_pkg::bus_rsp_t fetch_rsp,
    input  logic              fetch_rsp_ready,
    output logic              data_rsp_valid,
    output bus_pkg::bus_rsp_t data_rsp,
    input  logic              data_rsp_ready,
    output logic              rsp_done
);
    import bus_pkg::*;

    bus_rsp_t sel_rsp;
    logic     sel_valid;
    logic     to_data;
    logic     port_ready;

    // Only one target can hold a response at a time
    assign sel_valid = clint_rsp_valid || ext_rsp_valid;
    assign sel_rsp   = clint_rsp_valid ? clint_rsp : ext_rsp;

    // Steer by the ID of the owning requester
    assign to_data = (sel_rsp.id == ID_DATA);

    assign fetch_rsp_valid = sel_valid && !to_data;
    assign data_rsp_valid  = sel_valid && to_data;
    assign fetch_rsp       = sel_rsp;
    assign data_rsp        = sel_rsp;

    assign port_ready = to_data ? data_rsp_ready : fetch_rsp_ready;

    assign clint_rsp_ready = clint_rsp_valid && port_ready;
    assign ext_rsp_ready   = !clint_rsp_valid && ext_rsp_valid && port_ready;

    // Frees the arbiter grant
    assign rsp_done = sel_valid && port_ready;

endmodule

// ==== source/bus_hub.sv ====
`timescale 1ns/1ps

module bus_hub (
    input  logic              clock,
    input  logic              reset,
    input  logic              fetch_req_valid,
    input  bus_pkg::addr_t    fetch_addr,
    output logic              fetch_req_ready,
    output logic              fetch_rsp_valid,
    output bus_pkg::bus_rsp_t fetch_rsp,
    input  logic              fetch_rsp_ready,
    input  logic              data_req_valid,
    input  bus_pkg::bus_req_t data_req,
    output logic              data_req_ready,
    output logic              data_rsp_valid,
    output bus_pkg::bus_rsp_t data_rsp,
    input  logic              data_rsp_ready,
    output logic              ext_req_valid,
    output bus_pkg::bus_req_t ext_req,
    input  logic              ext_req_ready,
    input  logic              ext_rsp_valid,
    input  bus_pkg::bus_rsp_t ext_rsp,
    output logic              ext_rsp_ready,
    output logic              timer_irq
);
    import bus_pkg::*;

    logic     clint_req_valid;
    bus_req_t clint_req;
    logic     clint_req_ready;
    logic     clint_rsp_valid;
    bus_rsp_t clint_rsp;
    logic     clint_rsp_ready;
    logic     rsp_done;

    request_arbiter u_request_arbiter (
        .clock           (clock),
        .reset           (reset),
        .fetch_req_valid (fetch_req_valid),
        .fetch_addr      (fetch_addr),
        .fetch_req_ready (fetch_req_ready),
        .data_req_valid  (data_req_valid),
        .data_req        (data_req),
        .data_req_ready  (data_req_ready),
        .rsp_done        (rsp_done),
        .clint_req_valid (clint_req_valid),
        .clint_req       (clint_req),
        .clint_req_ready (clint_req_ready),
        .ext_req_valid   (ext_req_valid),
        .ext_req         (ext_req),
        .ext_req_ready   (ext_req_ready)
    );

    clint_timer u_clint_timer (
        .clock     (clock),
        .reset     (reset),
        .req_valid (clint_req_valid),
        .req       (clint_req),
        .req_ready (clint_req_ready),
        .rsp_valid (clint_rsp_valid),
        .rsp       (clint_rsp),
        .rsp_ready (clint_rsp_ready),
        .timer_irq (timer_irq)
    );

    response_merge u_response_merge (
        .clint_rsp_valid (clint_rsp_valid),
        .clint_rsp       (clint_rsp),
        .clint_rsp_ready (clint_rsp_ready),
        .ext_rsp_valid   (ext_rsp_valid),
        .ext_rsp         (ext_rsp),
        .ext_rsp_ready   (ext_rsp_ready),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .fetch_rsp_ready (fetch_rsp_ready),
        .data_rsp_valid  (data_rsp_valid),
        .data_rsp        (data_rsp),
        .data_rsp_ready  (data_rsp_ready),
        .rsp_done        (rsp_done)
    );

endmodule

// ==== tests/bus_checker.sv ====
`timescale 1ns/1ps

module bus_checker (
    input  logic              clock,
    input  logic              reset,
    input  logic              fetch_req_valid,
    input  bus_pkg::addr_t    fetch_addr,
    input  logic              fetch_req_ready,
    input  logic              fetch_rsp_valid,
    input  bus_pkg::bus_rsp_t fetch_rsp,
    input  logic              fetch_rsp_ready,
    input  logic              data_req_valid,
    input  bus_pkg::bus_req_t data_req,
    input  logic              data_req_ready,
    input  logic              data_rsp_valid,
    input  bus_pkg::bus_rsp_t data_rsp,
    input  logic              data_rsp_ready,
    input  logic              ext_req_valid,
    input  bus_pkg::bus_req_t ext_req,
    input  logic              ext_req_ready,
    input  logic              ext_rsp_valid,
    input  bus_pkg::bus_rsp_t ext_rsp,
    input  logic              ext_rsp_ready,
    input  logic              timer_irq,
    input  logic              finished,
    output int                error_count,
    output int                check_count
);
    import bus_pkg::*;

    localparam data_t READ_PATTERN = 64'hA5A5_A5A5_A5A5_A5A5;

    // Kind 0 exact data, 1 mtime read, 2 mtimecmp write
    logic       q_port[$];
    bus_req_t   q_req[$];
    data_t      q_exp[$];
    logic [1:0] q_kind[$];
    data_t      model_mtime;
    data_t      shadow_cmp;
    data_t      last_mtime;
    logic       fetch_hold;
    bus_rsp_t   fetch_prev;

    initial begin
        error_count = 0;
        check_count = 0;
        shadow_cmp  = '1;
        last_mtime  = '0;
    end

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("FAILED at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic report(input string what);
        error_count++;
        $display("Error at %0d ns: %s", $time, what);
    endtask

    task automatic accept_request(input logic port, input bus_req_t req);
        addr_t      offset;
        data_t      exp;
        logic [1:0] kind;
        offset = req.addr - CLINT_BASE;
        exp    = '0;
        kind   = 2'd0;
        if (q_port.size() != 0) begin
            report("request accepted while a transaction was in flight");
        end
        if (req.addr >= CLINT_BASE && req.addr < CLINT_BASE + CLINT_SIZE) begin
            if (req.write && offset == MTIMECMP_OFFSET) begin
                kind = 2'd2;
            end else if (!req.write && offset == MTIMECMP_OFFSET) begin
                exp = shadow_cmp;
            end else if (!req.write && offset == MTIME_OFFSET) begin
                kind = 2'd1;
            end
        end else if (!req.write) begin
            exp = {32'b0, req.addr} ^ READ_PATTERN;
        end
        q_port.push_back(port);
        q_req.push_back(req);
        q_exp.push_back(exp);
        q_kind.push_back(kind);
    endtask

    task automatic take_response(input logic port, input bus_rsp_t rsp);
        bus_req_t   req;
        logic [1:0] kind;
        data_t      exp;
        if (q_port.size() == 0) begin
            report("response arrived with no request pending");
            return;
        end
        // One transaction in flight, so responses follow acceptance order
        check_value("response port", q_port.pop_front(), port);
        req  = q_req.pop_front();
        exp  = q_exp.pop_front();
        kind = q_kind.pop_front();
        check_value("rsp.id", req.id, rsp.id);
        if (kind == 2'd1) begin
            if (rsp.data < last_mtime || rsp.data > model_mtime) begin
                report("mtime read out of range");
            end
            last_mtime = rsp.data;
        end else begin
            check_value("rsp.data", exp, rsp.data);
        end
        if (kind == 2'd2) begin
            for (int i = 0; i < STRB_WIDTH; i++) begin
                if (req.strb[i]) begin
                    shadow_cmp[8*i +: 8] = req.data[8*i +: 8];
                end
            end
        end
        check_value("timer_irq", model_mtime >= shadow_cmp, timer_irq);
    endtask

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            model_mtime <= '0;
        end else begin
            model_mtime <= model_mtime + 64'd1;
        end
    end

    always @(posedge clock) begin
        bus_req_t req;
        if (!reset) begin
            if (fetch_hold && (!fetch_rsp_valid || fetch_rsp !== fetch_prev)) begin
                report("fetch response changed while stalled");
            end
            fetch_hold = fetch_rsp_valid && !fetch_rsp_ready;
            fetch_prev = fetch_rsp;
            if (fetch_rsp_valid && fetch_rsp_ready) begin
                take_response(1'b0, fetch_rsp);
            end
            if (data_rsp_valid && data_rsp_ready) begin
                take_response(1'b1, data_rsp);
            end
            // External response is released only when its requester takes it
            if (ext_rsp_valid) begin
                check_value("ext_rsp_ready",
                            (ext_rsp.id == ID_DATA) ? data_rsp_ready : fetch_rsp_ready,
                            ext_rsp_ready);
            end
            if (ext_req_valid && ext_req_ready) begin
                if (q_req.size() == 0) begin
                    report("external request with nothing accepted");
                end else begin
                    check_value("ext_req", q_req[0], ext_req);
                end
            end
            if (data_req_valid && fetch_req_valid) begin
                check_value("fetch_req_ready", 1'b0, fetch_req_ready);
            end
            if (data_req_valid && data_req_ready) begin
                req    = data_req;
                req.id = ID_DATA;
                accept_request(1'b1, req);
            end else if (fetch_req_valid && fetch_req_ready) begin
                req      = '0;
                req.id   = ID_FETCH;
                req.addr = fetch_addr;
                accept_request(1'b0, req);
            end
        end
    end

    always @(posedge finished) begin
        if (q_port.size() != 0) begin
            report("requests left without a response");
        end
    end

endmodule

// ==== tests/tb_bus_hub.sv ====
`timescale 1ns/1ps

module tb_bus_hub;
    import bus_pkg::*;

    localparam int    NUM_ENTRIES    = 14;
    localparam int    TIMEOUT_CYCLES = NUM_ENTRIES * 12 + 50;
    localparam data_t READ_PATTERN   = 64'hA5A5_A5A5_A5A5_A5A5;

    typedef struct packed {
        logic       port;
        addr_t      addr;
        logic       write;
        data_t      data;
        strb_t      strb;
        logic [3:0] stall;
        logic       pair;
        logic [1:0] lag;
    } entry_t;

    logic     clock;
    logic     reset;
    logic     fetch_req_valid;
    addr_t    fetch_addr;
    logic     fetch_req_ready;
    logic     fetch_rsp_valid;
    bus_rsp_t fetch_rsp;
    logic     fetch_rsp_ready;
    logic     data_req_valid;
    bus_req_t data_req;
    logic     data_req_ready;
    logic     data_rsp_valid;
    bus_rsp_t data_rsp;
    logic     data_rsp_ready;
    logic     ext_req_valid;
    bus_req_t ext_req;
    logic     ext_req_ready;
    logic     ext_rsp_valid;
    bus_rsp_t ext_rsp;
    logic     ext_rsp_ready;
    logic     timer_irq;
    logic     finished;
    int       error_count;
    int       check_count;
    int       cycle_count;
    int unsigned lcg_state = 10;
    logic       ext_busy;
    logic [1:0] ext_delay;
    entry_t     test_table[NUM_ENTRIES];

    bus_hub u_bus_hub (.*);

    bus_checker u_checker (.*);

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) & 32'h7FFF;
    endfunction

    function automatic entry_t make_entry(logic port, addr_t addr, logic write, data_t data,
                                          strb_t strb, logic [3:0] stall, logic pair,
                                          logic [1:0] lag);
        return '{port, addr, write, data, strb, stall, pair, lag};
    endfunction

    // Port 0 is fetch, port 1 is data
    task automatic send(input entry_t e);
        repeat (e.lag) @(posedge clock);
        @(posedge clock);
        if (e.port) begin
            data_req_valid <= 1'b1;
            data_req       <= '{4'hF, e.addr, e.write, e.data, e.strb};
            data_rsp_ready <= (e.stall == 0);
        end else begin
            fetch_req_valid <= 1'b1;
            fetch_addr      <= e.addr;
            fetch_rsp_ready <= (e.stall == 0);
        end
        do @(negedge clock); while (!(e.port ? data_req_ready : fetch_req_ready));
        @(posedge clock);
        if (e.port) data_req_valid <= 1'b0;
        else fetch_req_valid <= 1'b0;
        do @(negedge clock); while (!(e.port ? data_rsp_valid : fetch_rsp_valid));
        if (e.stall != 0) begin
            repeat (e.stall) @(posedge clock);
            if (e.port) data_rsp_ready <= 1'b1;
            else fetch_rsp_ready <= 1'b1;
        end
        @(posedge clock);
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // External memory model with random latency
    always @(posedge clock or posedge reset) begin
        if (reset) begin
            ext_req_ready <= 1'b0;
            ext_rsp_valid <= 1'b0;
            ext_busy      <= 1'b0;
            ext_delay     <= '0;
        end else begin
            if (ext_rsp_valid && ext_rsp_ready) ext_rsp_valid <= 1'b0;
            if (ext_req_valid && ext_req_ready) begin
                ext_req_ready <= 1'b0;
                ext_busy      <= 1'b1;
                ext_delay     <= 2'(next_random() % 4);
                ext_rsp.id    <= ext_req.id;
                ext_rsp.data  <= ext_req.write ? '0 : ({32'b0, ext_req.addr} ^ READ_PATTERN);
            end else if (ext_busy) begin
                if (ext_delay == 0) begin
                    ext_busy      <= 1'b0;
                    ext_rsp_valid <= 1'b1;
                end else begin
                    ext_delay <= ext_delay - 2'd1;
                end
            end else if (ext_req_valid && !ext_rsp_valid) begin
                ext_req_ready <= 1'b1;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the stimulus table did not finish in %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        int i;
        reset = 1'b1;
        cycle_count = 0;
        fetch_req_valid = 1'b0;
        fetch_addr = '0;
        fetch_rsp_ready = 1'b1;
        data_req_valid = 1'b0;
        data_req = '0;
        data_rsp_ready = 1'b1;
        ext_req_ready = 1'b0;
        ext_rsp_valid = 1'b0;
        ext_rsp = '0;
        finished = 1'b0;
        test_table[0]  = make_entry(0, 32'h8000_0000, 0, 0, 0, 0, 0, 0);
        test_table[1]  = make_entry(1, 32'h0200_4000, 1, 64'h1234, 8'hFF, 0, 0, 0);
        test_table[2]  = make_entry(1, 32'h0200_4000, 0, 0, 0, 0, 0, 0);
        test_table[3]  = make_entry(1, 32'h0200_BFF8, 0, 0, 0, 0, 0, 0);
        test_table[4]  = make_entry(1, 32'h0200_BFF8, 0, 0, 0, 0, 0, 0);
        test_table[5]  = make_entry(1, 32'h0200_4000, 1, 64'h5, 8'hFF, 0, 0, 0);
        test_table[6]  = make_entry(1, 32'h0200_4000, 1, '1, 8'hFF, 0, 0, 0);
        // Data and fetch raised together
        test_table[7]  = make_entry(1, 32'h8000_1000, 0, 0, 0, 0, 1, 0);
        test_table[8]  = make_entry(0, 32'h8000_2000, 0, 0, 0, 0, 0, 0);
        // Data request raised while the fetch response is stalled
        test_table[9]  = make_entry(0, 32'h8000_3000, 0, 0, 0, 5, 1, 0);
        test_table[10] = make_entry(1, 32'h8000_4000, 1, 64'hDEAD_BEEF_0BAD_F00D, 8'h0F,
                                    0, 0, 2);
        test_table[11] = make_entry(1, 32'h0200_4000, 1, 64'hABCD, 8'h03, 0, 0, 0);
        test_table[12] = make_entry(1, 32'h0200_4000, 0, 0, 0, 0, 0, 0);
        test_table[13] = make_entry(0, 32'h0200_BFF8, 0, 0, 0, 0, 0, 0);
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        i = 0;
        while (i < NUM_ENTRIES) begin
            if (test_table[i].pair) begin
                fork
                    send(test_table[i]);
                    send(test_table[i + 1]);
                join
                i += 2;
            end else begin
                send(test_table[i]);
                i += 1;
            end
        end
        repeat (2) @(posedge clock);
        finished <= 1'b1;
        repeat (2) @(posedge clock);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== bus_hub.f ====
source/bus_pkg.sv
source/request_arbiter.sv
source/clint_timer.sv
source/response_merge.sv
source/bus_hub.sv
tests/bus_checker.sv
tests/tb_bus_hub.sv

// ==== Bender.yml ====
package:
  name: bus_hub

sources:
  - source/bus_pkg.sv
  - source/request_arbiter.sv
  - source/clint_timer.sv
  - source/response_merge.sv
  - source/bus_hub.sv
  - target: test
    files:
      - tests/bus_checker.sv
      - tests/tb_bus_hub.sv
